// File: sim/trap_testdata.txt
# stage: 0 id_valid id_pc id_op id_f3 id_imm br_est br_tgt ex_valid ex_pc ex_op ex_f3 ex_alu exp_rv exp_pc
# wishbone: 1 we adr wdata exp_rdata (exp_rdata unused on writes), all fields hex
1 0 305 00000000 00001000
1 1 305 00002003 00000000
1 0 305 00000000 00002000
0 1 00000100 73 0 000 0 00000000 0 00000000 00 0 00000000 1 00002000
1 0 341 00000000 00000100
1 0 342 00000000 0000000b
1 0 343 00000000 00000000
0 1 00000204 73 0 001 0 00000000 0 00000000 00 0 00000000 1 00002000
1 0 342 00000000 00000003
1 0 343 00000000 00000204
0 0 00000000 00 0 000 0 00000000 1 00000300 03 2 00001002 1 00002000
1 0 343 00000000 00001002
0 0 00000000 00 0 000 0 00000000 1 00000310 23 1 00000401 1 00002000
1 0 342 00000000 00000006
0 0 00000000 00 0 000 0 00000000 1 00000320 03 2 00001004 0 00000000
0 0 00000000 00 0 000 0 00000000 1 00000324 03 0 00000003 0 00000000
0 0 00000000 00 0 000 0 00000000 1 00000330 6f 0 00000a02 1 00002000
1 0 342 00000000 00000000
0 0 00000000 00 0 000 0 00000000 1 00000334 67 0 00000b01 1 00002000
1 0 343 00000000 00000b01
0 1 00000400 63 0 000 1 00000502 0 00000000 00 0 00000000 1 00002000
1 0 343 00000000 00000502
0 1 00000600 73 0 000 0 00000000 1 000005fc 23 2 00000806 1 00002000
1 0 341 00000000 000005fc
1 0 342 00000000 00000006
1 1 341 00003001 00000000
0 1 00000610 73 0 302 0 00000000 0 00000000 00 0 00000000 1 00003000
1 0 342 00000000 00000006
0 1 00000700 0f 1 000 0 00000000 0 00000000 00 0 00000000 1 00000704
1 0 341 00000000 00003000
1 1 342 00000055 00000000
1 0 342 00000000 00000006
1 0 123 00000000 00000000

// File: sources.f
rtl/riscv_isa_pkg.sv
rtl/trap_pkg.sv
rtl/exception_detector.sv
rtl/trap_controller.sv
rtl/csr_file.sv
rtl/trap_unit_top.sv
sim/trap_checker.sv
sim/tb_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_top
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        id_valid = 1'b0;
    logic [31:0] id_pc = '0;
    logic [6:0]  id_opcode = '0;
    logic [2:0]  id_funct3 = '0;
    logic [11:0] id_raw_imm = '0;
    logic        branch_estimation = 1'b0;
    logic [31:0] branch_target = '0;
    logic        ex_valid = 1'b0;
    logic [31:0] ex_pc = '0;
    logic [6:0]  ex_opcode = '0;
    logic [2:0]  ex_funct3 = '0;
    logic [31:0] ex_alu_result = '0;
    logic        wb_cyc = 1'b0;
    logic        wb_stb = 1'b0;
    logic        wb_we = 1'b0;
    logic [11:0] wb_adr = '0;
    logic [31:0] wb_dat_w = '0;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        flush;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        stage_check = 1'b0;
    logic        exp_redirect = 1'b0;
    logic [31:0] exp_pc = '0;
    logic        rd_check = 1'b0;
    logic [31:0] exp_rdata = '0;
    int          errors;
    int          checks;
    string       lines[$];                // vector lines without comments
    int          n_vec = 0;
    int          bad_lines = 0;
    logic [15:0] lfsr = 16'd19797;

    trap_unit_top dut0 (.*);

    trap_checker checker0 (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic load_vectors();
        int    fd;
        int    rc;
        string line;
        fd = $fopen("sim/trap_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 1 && line.getc(0) != "#") lines.push_back(line);
            end
            $fclose(fd);
        end
        n_vec = lines.size();
    endtask

    task automatic apply_stage(input string line);
        logic        idv;
        logic        exv;
        logic        est;
        logic        rv;
        logic [31:0] rpc;
        int          rc;
        rc = $sscanf(line, "%*h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     idv, id_pc, id_opcode, id_funct3, id_raw_imm, est,
                     branch_target, exv, ex_pc, ex_opcode, ex_funct3, ex_alu_result,
                     rv, rpc);
        if (rc != 14) begin
            $display("malformed stage vector: %s", line);
            bad_lines++;
        end
        id_valid          = idv;
        ex_valid          = exv;
        branch_estimation = est;
        @(negedge clk);
        id_valid     = 1'b0;            // one cycle only
        ex_valid     = 1'b0;
        exp_redirect = rv;
        exp_pc       = rpc;
        stage_check  = 1'b1;
        @(negedge clk);
        stage_check = 1'b0;
    endtask

    task automatic wb_access(input string line);
        logic        we;
        logic [11:0] adr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        int          rc;
        rc = $sscanf(line, "%*h %h %h %h %h", we, adr, wdata, rdata);
        if (rc != 4) begin
            $display("malformed wishbone vector: %s", line);
            bad_lines++;
        end
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = we;
        wb_adr    = adr;
        wb_dat_w  = wdata;
        rd_check  = !we;
        exp_rdata = rdata;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(negedge clk);                 // stb held through the ack edge
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        rd_check = 1'b0;
    endtask

    task automatic insert_idle();
        logic [2:0] idle;
        int         b;
        idle = '0;
        for (b = 0; b < 3; b++) begin
            idle = {idle[1:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        repeat (idle) @(negedge clk);
    endtask

    initial begin
        logic [3:0] kind;
        int         rc;
        load_vectors();
        if (n_vec == 0) begin
            $display("no vectors could be read from sim/trap_testdata.txt");
            $display("TEST FAIL");
            $finish;
        end else begin
            repeat (10) @(negedge clk);
            rst_n = 1'b1;
            foreach (lines[i]) begin
                rc = $sscanf(lines[i], "%h", kind);
                if (rc == 1 && kind == 4'd0) begin
                    apply_stage(lines[i]);
                end else if (rc == 1 && kind == 4'd1) begin
                    wb_access(lines[i]);
                end else begin
                    $display("unknown vector kind: %s", lines[i]);
                    bad_lines++;
                end
                insert_idle();
            end
            @(negedge clk);
            $display("checks %0d, errors %0d, malformed lines %0d", checks, errors, bad_lines);
            if (errors == 0 && bad_lines == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

    // worst case vector is well under 12 cycles
    initial begin
        wait (n_vec > 0);
        repeat (n_vec * 12 + 10) @(posedge clk);
        $display("timeout: run did not complete in %0d ns", (n_vec * 12 + 10) * 20);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: sim/trap_checker.sv
`timescale 1ns/1ps

module trap_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           redirect_valid,
    input  logic [riscv_isa_pkg::xlen-1:0] redirect_pc,
    input  logic                           flush,
    input  logic                           wb_ack,
    input  logic [riscv_isa_pkg::xlen-1:0] wb_dat_r,
    input  logic                           stage_check,   // redirect expected this cycle
    input  logic                           exp_redirect,
    input  logic [riscv_isa_pkg::xlen-1:0] exp_pc,
    input  logic                           rd_check,      // wishbone read in flight
    input  logic [riscv_isa_pkg::xlen-1:0] exp_rdata,
    output int                             errors,
    output int                             checks
);

    int error_count = 0;
    int check_count = 0;

    assign errors = error_count;
    assign checks = check_count;

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        error_count = error_count + 1;
    endtask

    // outputs were registered on the previous edge, sampled before they move
    always @(posedge clk) begin
        if (rst_n) begin
            if (flush !== redirect_valid) begin
                report_mismatch($sformatf("flush %0b but redirect_valid %0b",
                                          flush, redirect_valid));
            end
            if (stage_check) begin
                check_count = check_count + 1;
                if (redirect_valid !== exp_redirect) begin
                    report_mismatch($sformatf("redirect_valid %0b, expected %0b",
                                              redirect_valid, exp_redirect));
                end else if (exp_redirect && redirect_pc !== exp_pc) begin
                    report_mismatch($sformatf("redirect_pc %h, expected %h",
                                              redirect_pc, exp_pc));
                end
            end else if (redirect_valid) begin   // nothing trapped a cycle ago
                report_mismatch($sformatf("unexpected redirect to %h", redirect_pc));
            end
            if (wb_ack && rd_check) begin
                check_count = check_count + 1;
                if (wb_dat_r !== exp_rdata) begin
                    report_mismatch($sformatf("wb read data %h, expected %h",
                                              wb_dat_r, exp_rdata));
                end
            end
        end
    end

endmodule

// File: rtl/trap_unit_top.sv
`timescale 1ns/1ps

module trap_unit_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           id_valid,
    input  logic [riscv_isa_pkg::xlen-1:0] id_pc,
    input  logic [6:0]                     id_opcode,
    input  logic [2:0]                     id_funct3,
    input  logic [11:0]                    id_raw_imm,
    input  logic                           branch_estimation,
    input  logic [riscv_isa_pkg::xlen-1:0] branch_target,
    input  logic                           ex_valid,
    input  logic [riscv_isa_pkg::xlen-1:0] ex_pc,
    input  logic [6:0]                     ex_opcode,
    input  logic [2:0]                     ex_funct3,
    input  logic [riscv_isa_pkg::xlen-1:0] ex_alu_result,
    output logic                           redirect_valid,
    output logic [riscv_isa_pkg::xlen-1:0] redirect_pc,
    output logic                           flush,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [11:0]                    wb_adr,
    input  logic [riscv_isa_pkg::xlen-1:0] wb_dat_w,
    output logic [riscv_isa_pkg::xlen-1:0] wb_dat_r,
    output logic                           wb_ack
);

    logic                               trapped;
    logic [trap_pkg::trap_status_w-1:0] trap_status;
    logic                               trap_from_ex;
    logic                               trap_we;
    logic [riscv_isa_pkg::xlen-1:0]     trap_mepc;
    logic [riscv_isa_pkg::xlen-1:0]     trap_mcause;
    logic [riscv_isa_pkg::xlen-1:0]     trap_mtval;
    logic [riscv_isa_pkg::xlen-1:0]     mtvec;
    logic [riscv_isa_pkg::xlen-1:0]     mepc;

    exception_detector detector0 (
        .id_valid           (id_valid),
        .id_opcode          (id_opcode),
        .id_funct3          (id_funct3),
        .id_raw_imm         (id_raw_imm),
        .branch_estimation  (branch_estimation),
        .branch_target_lsbs (branch_target[1:0]),
        .ex_valid           (ex_valid),
        .ex_opcode          (ex_opcode),
        .ex_funct3          (ex_funct3),
        .alu_result_lsbs    (ex_alu_result[1:0]),
        .trapped            (trapped),
        .trap_status        (trap_status),
        .trap_from_ex       (trap_from_ex)
    );

    trap_controller controller0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .trapped        (trapped),
        .trap_status    (trap_status),
        .trap_from_ex   (trap_from_ex),
        .id_pc          (id_pc),
        .ex_pc          (ex_pc),
        .ex_alu_result  (ex_alu_result),
        .branch_target  (branch_target),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .trap_we        (trap_we),
        .trap_mepc      (trap_mepc),
        .trap_mcause    (trap_mcause),
        .trap_mtval     (trap_mtval)
    );

    csr_file csr0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .trap_we     (trap_we),
        .trap_mepc   (trap_mepc),
        .trap_mcause (trap_mcause),
        .trap_mtval  (trap_mtval),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

endmodule

// File: rtl/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [11:0]                    wb_adr,     // CSR address
    input  logic [riscv_isa_pkg::xlen-1:0] wb_dat_w,
    input  logic                           trap_we,
    input  logic [riscv_isa_pkg::xlen-1:0] trap_mepc,
    input  logic [riscv_isa_pkg::xlen-1:0] trap_mcause,
    input  logic [riscv_isa_pkg::xlen-1:0] trap_mtval,
    output logic [riscv_isa_pkg::xlen-1:0] wb_dat_r,
    output logic                           wb_ack,
    output logic [riscv_isa_pkg::xlen-1:0] mtvec,
    output logic [riscv_isa_pkg::xlen-1:0] mepc
);

    logic                           wb_req;    // new access, not yet acked
    logic                           wb_write;
    logic [riscv_isa_pkg::xlen-1:0] mcause;
    logic [riscv_isa_pkg::xlen-1:0] mtval;
    logic [riscv_isa_pkg::xlen-1:0] rd_data;

    assign wb_req   = wb_cyc && wb_stb && !wb_ack;  // stb still high in the ack cycle
    assign wb_write = wb_req && wb_we;

    always_comb begin
        case (wb_adr)
            trap_pkg::csr_mtvec:  rd_data = mtvec;
            trap_pkg::csr_mepc:   rd_data = mepc;
            trap_pkg::csr_mcause: rd_data = mcause;
            trap_pkg::csr_mtval:  rd_data = mtval;
            default:              rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_dat_r <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec  <= trap_pkg::mtvec_reset;
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else begin
            if (wb_write) begin
                case (wb_adr)
                    trap_pkg::csr_mtvec: mtvec <= {wb_dat_w[riscv_isa_pkg::xlen-1:2], 2'b00};
                    trap_pkg::csr_mepc:  mepc  <= {wb_dat_w[riscv_isa_pkg::xlen-1:2], 2'b00};
                    default: ;                          // mcause, mtval read only here
                endcase
            end
            if (trap_we) begin                          // trap overrides bus write
                mepc   <= {trap_mepc[riscv_isa_pkg::xlen-1:2], 2'b00};
                mcause <= trap_mcause;
                mtval  <= trap_mtval;
            end
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside an active cycle");

endmodule

// File: rtl/trap_controller.sv
`timescale 1ns/1ps

module trap_controller (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               trapped,
    input  logic [trap_pkg::trap_status_w-1:0] trap_status,
    input  logic                               trap_from_ex,
    input  logic [riscv_isa_pkg::xlen-1:0]     id_pc,
    input  logic [riscv_isa_pkg::xlen-1:0]     ex_pc,
    input  logic [riscv_isa_pkg::xlen-1:0]     ex_alu_result,
    input  logic [riscv_isa_pkg::xlen-1:0]     branch_target,
    input  logic [riscv_isa_pkg::xlen-1:0]     mtvec,
    input  logic [riscv_isa_pkg::xlen-1:0]     mepc,
    output logic                               redirect_valid,
    output logic [riscv_isa_pkg::xlen-1:0]     redirect_pc,
    output logic                               flush,
    output logic                               trap_we,
    output logic [riscv_isa_pkg::xlen-1:0]     trap_mepc,
    output logic [riscv_isa_pkg::xlen-1:0]     trap_mcause,
    output logic [riscv_isa_pkg::xlen-1:0]     trap_mtval
);

    logic                           take;      // trap accepted this cycle
    logic                           record;    // writes mepc/mcause/mtval
    logic [riscv_isa_pkg::xlen-1:0] src_pc;
    logic [riscv_isa_pkg::xlen-1:0] target;
    logic [riscv_isa_pkg::xlen-1:0] cause;
    logic [riscv_isa_pkg::xlen-1:0] tval;

    assign src_pc = trap_from_ex ? ex_pc : id_pc;

    always_comb begin
        take   = trapped && !flush;            // stages squashed while flushing
        record = 1'b1;
        target = mtvec;
        cause  = '0;
        tval   = '0;
        case (trap_status)
            trap_pkg::trap_fencei: begin
                record = 1'b0;
                target = src_pc + 32'd4;       // restart after FENCE.I
            end
            trap_pkg::trap_mret: begin
                record = 1'b0;
                target = mepc;
            end
            trap_pkg::trap_ecall: begin
                cause = trap_pkg::cause_ecall;
            end
            trap_pkg::trap_ebreak: begin
                cause = trap_pkg::cause_ebreak;
                tval  = src_pc;
            end
            trap_pkg::trap_misaligned_instruction: begin
                cause = trap_pkg::cause_misaligned_instruction;
                tval  = trap_from_ex ? ex_alu_result : branch_target;
            end
            trap_pkg::trap_misaligned_load: begin
                cause = trap_pkg::cause_misaligned_load;
                tval  = ex_alu_result;
            end
            trap_pkg::trap_misaligned_store: begin
                cause = trap_pkg::cause_misaligned_store;
                tval  = ex_alu_result;
            end
            default: begin                     // trap_none, unknown SYSTEM imm
                take   = 1'b0;
                record = 1'b0;
            end
        endcase
    end

    // CSR write lands on the same edge as the redirect
    assign trap_we     = take && record;
    assign trap_mepc   = src_pc;
    assign trap_mcause = cause;
    assign trap_mtval  = tval;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
            flush          <= 1'b0;
        end else begin
            redirect_valid <= take;
            flush          <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            redirect_pc <= target;
        end
    end

    a_trap_we_single: assert property (@(posedge clk) disable iff (!rst_n)
        trap_we |=> !trap_we)
        else $error("trap_we held two cycles");

endmodule

// File: rtl/exception_detector.sv
`timescale 1ns/1ps

module exception_detector (
    input  logic                              id_valid,
    input  logic [6:0]                        id_opcode,
    input  logic [2:0]                        id_funct3,
    input  logic [11:0]                       id_raw_imm,         // funct12 for SYSTEM
    input  logic                              branch_estimation,  // predicted taken
    input  logic [1:0]                        branch_target_lsbs,
    input  logic                              ex_valid,
    input  logic [6:0]                        ex_opcode,
    input  logic [2:0]                        ex_funct3,
    input  logic [1:0]                        alu_result_lsbs,    // jump target or mem address
    output logic                              trapped,
    output logic [trap_pkg::trap_status_w-1:0] trap_status,
    output logic                              trap_from_ex        // EX won arbitration
);

    logic                               id_trapped;
    logic [trap_pkg::trap_status_w-1:0] id_status;
    logic                               ex_trapped;
    logic [trap_pkg::trap_status_w-1:0] ex_status;

    // ID stage: SYSTEM, FENCE.I, predicted branch
    always_comb begin
        id_trapped = 1'b0;
        id_status  = trap_pkg::trap_none;
        if (id_valid) begin
            case (id_opcode)
                riscv_isa_pkg::opcode_fence: begin
                    if (id_funct3 == riscv_isa_pkg::funct3_fencei) begin
                        id_trapped = 1'b1;
                        id_status  = trap_pkg::trap_fencei;
                    end
                end
                riscv_isa_pkg::opcode_system: begin
                    if (id_funct3 == riscv_isa_pkg::funct3_priv) begin
                        id_trapped = 1'b1;        // unmatched imm stays trap_none
                        if (id_raw_imm == riscv_isa_pkg::imm_mret) begin
                            id_status = trap_pkg::trap_mret;
                        end else if (id_raw_imm == 12'h001) begin
                            id_status = trap_pkg::trap_ebreak;
                        end else if (id_raw_imm == 12'h000) begin
                            id_status = trap_pkg::trap_ecall;
                        end
                    end
                end
                riscv_isa_pkg::opcode_branch: begin
                    if (branch_estimation && branch_target_lsbs != 2'b00) begin
                        id_trapped = 1'b1;
                        id_status  = trap_pkg::trap_misaligned_instruction;
                    end
                end
                default: ;
            endcase
        end
    end

    // EX stage: load/store address and jump target alignment
    always_comb begin
        ex_trapped = 1'b0;
        ex_status  = trap_pkg::trap_none;
        if (ex_valid) begin
            case (ex_opcode)
                riscv_isa_pkg::opcode_load: begin
                    if (((ex_funct3 == riscv_isa_pkg::funct3_lh ||
                          ex_funct3 == riscv_isa_pkg::funct3_lhu) && alu_result_lsbs[0]) ||
                        (ex_funct3 == riscv_isa_pkg::funct3_lw && alu_result_lsbs != 2'b00)) begin
                        ex_trapped = 1'b1;
                        ex_status  = trap_pkg::trap_misaligned_load;
                    end
                end
                riscv_isa_pkg::opcode_store: begin
                    if ((ex_funct3 == riscv_isa_pkg::funct3_sh && alu_result_lsbs[0]) ||
                        (ex_funct3 == riscv_isa_pkg::funct3_sw && alu_result_lsbs != 2'b00)) begin
                        ex_trapped = 1'b1;
                        ex_status  = trap_pkg::trap_misaligned_store;
                    end
                end
                riscv_isa_pkg::opcode_jal,
                riscv_isa_pkg::opcode_jalr: begin
                    if (alu_result_lsbs != 2'b00) begin  // no C extension, word aligned
                        ex_trapped = 1'b1;
                        ex_status  = trap_pkg::trap_misaligned_instruction;
                    end
                end
                default: ;
            endcase
        end
    end

    // older instruction wins
    always_comb begin
        trap_from_ex = ex_trapped;
        trapped      = ex_trapped || id_trapped;
        trap_status  = ex_trapped ? ex_status : id_status;
    end

endmodule

// File: rtl/trap_pkg.sv
package trap_pkg;

    localparam int trap_status_w = 3;

    // detector status codes
    localparam logic [trap_status_w-1:0] trap_none                   = 3'd0;
    localparam logic [trap_status_w-1:0] trap_fencei                 = 3'd1;
    localparam logic [trap_status_w-1:0] trap_ecall                  = 3'd2;
    localparam logic [trap_status_w-1:0] trap_ebreak                 = 3'd3;
    localparam logic [trap_status_w-1:0] trap_mret                   = 3'd4;
    localparam logic [trap_status_w-1:0] trap_misaligned_instruction = 3'd5;
    localparam logic [trap_status_w-1:0] trap_misaligned_load        = 3'd6;
    localparam logic [trap_status_w-1:0] trap_misaligned_store       = 3'd7;

    // mcause exception codes, interrupt bit always clear here
    localparam logic [riscv_isa_pkg::xlen-1:0] cause_misaligned_instruction = 32'd0;
    localparam logic [riscv_isa_pkg::xlen-1:0] cause_ebreak                 = 32'd3;
    localparam logic [riscv_isa_pkg::xlen-1:0] cause_misaligned_load        = 32'd4;
    localparam logic [riscv_isa_pkg::xlen-1:0] cause_misaligned_store       = 32'd6;
    localparam logic [riscv_isa_pkg::xlen-1:0] cause_ecall                  = 32'd11;

    // machine CSR addresses
    localparam logic [11:0] csr_mtvec  = 12'h305;
    localparam logic [11:0] csr_mepc   = 12'h341;
    localparam logic [11:0] csr_mcause = 12'h342;
    localparam logic [11:0] csr_mtval  = 12'h343;

    // handler base after reset, direct mode
    localparam logic [riscv_isa_pkg::xlen-1:0] mtvec_reset = 32'h0000_1000;

endpackage

// File: rtl/riscv_isa_pkg.sv
package riscv_isa_pkg;

    localparam int xlen = 32;                        // data and address width

    // major opcodes, inst[6:0]
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_fence  = 7'b0001111; // FENCE and FENCE.I
    localparam logic [6:0] opcode_system = 7'b1110011; // ECALL, EBREAK, MRET, CSR ops

    // load widths
    localparam logic [2:0] funct3_lh  = 3'b001;
    localparam logic [2:0] funct3_lhu = 3'b101;
    localparam logic [2:0] funct3_lw  = 3'b010;

    // store widths
    localparam logic [2:0] funct3_sh = 3'b001;
    localparam logic [2:0] funct3_sw = 3'b010;

    localparam logic [2:0] funct3_fencei = 3'b001;   // Zifencei
    localparam logic [2:0] funct3_priv   = 3'b000;   // privileged group of SYSTEM

    localparam logic [11:0] imm_mret = 12'h302;      // funct12 of MRET

endpackage
